//--- branch_predictor.f
+incdir+verilog
verilog/bp_pkg.sv
verilog/bht_way_match.sv
verilog/bht_store.sv
verilog/branch_resolve.sv
verilog/fetch_pc_unit.sv
verilog/branch_predictor.sv
test/tb_branch_predictor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the branch predictor testbench with verilator
# the golden file path is relative to the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_branch_predictor -f branch_predictor.f \
	&& ./obj_dir/Vtb_branch_predictor | tee /dev/stderr \
		| grep -F "*** TEST PASSED ***" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- test/bp_golden.txt
// alloc: valid jump branch pc target | resolve: valid jump btype zero less pc target
// expected: if_pc if_prediction flush redirect_pc | one cycle per line, all hex
// idle after reset, then not-taken compares on pcs that miss
0 0 0 000 000   0 0 00 0 0 000 000   000 0 0 001
0 0 0 000 000   1 0 20 0 1 100 200   001 0 0 101
1 1 0 005 040   1 0 10 1 0 101 200   002 0 0 102
0 0 0 000 000   1 0 08 1 0 102 200   003 0 0 103
0 0 0 000 000   1 0 04 0 1 103 200   004 0 0 104
// jump at 005 predicted taken, branch 04a allocated weakly not taken
1 0 1 04a 070   1 0 02 0 0 104 200   005 1 0 105
0 0 0 000 000   1 0 01 1 1 105 200   040 0 0 106
// two taken resolutions of 04a, first one flushes
0 0 0 000 000   1 0 20 1 0 04a 070   041 0 1 070
0 0 0 000 000   1 0 20 1 0 04a 070   070 0 0 070
0 0 0 000 000   1 1 00 0 0 0f0 04a   071 0 1 04a
// 04a now fetched taken, but resolves not taken and redirects to pc plus one
1 1 0 01c 300   1 0 04 0 1 04a 070   04a 1 1 04b
// five jumps into set c while 04a saturates
1 1 0 02c 310   1 0 08 0 1 04a 070   04b 0 0 070
1 1 0 03c 320   1 0 02 0 1 04a 070   04c 0 0 070
1 1 0 04c 330   1 0 10 0 0 04a 070   04d 0 0 070
1 1 0 05c 340   1 0 01 0 1 04a 070   04e 0 1 04b
0 0 0 000 000   1 0 20 0 1 04a 070   04b 0 1 04b
// 01c was evicted, 02c still predicts taken
0 0 0 000 000   1 1 00 0 0 3f0 01c   04b 0 1 01c
0 0 0 000 000   1 0 04 1 1 04a 070   01c 0 0 04b
0 0 0 000 000   1 1 00 0 0 3f1 02c   01d 0 1 02c
0 0 0 000 000   1 1 00 0 0 3f2 04a   02c 1 1 04a
// 04a has dropped to not taken
0 0 0 000 000   1 0 08 0 1 04a 070   04a 0 1 070
0 0 0 000 000   0 0 00 0 0 000 000   070 0 0 001
0 0 0 000 000   0 0 00 0 0 000 000   071 0 0 001

//--- test/tb_branch_predictor.sv
`default_nettype none
`timescale 1ns/1ns

`include "bp_defines.svh"

module tb_branch_predictor;

	import bp_pkg::*;

	// hex words per golden line
	localparam int FIELDS       = 16;
	localparam int NUM_VEC      = 23;
	localparam int NUM_WORDS    = FIELDS * NUM_VEC;
	localparam int RESET_CYCLES = 10;
	// golden lines plus margin, covers the reset cycles
	localparam int MAX_CYCLES   = NUM_VEC + 20;
	localparam string GOLDEN_PATH = "test/bp_golden.txt";

	logic                CLK;
	logic                arst_n;
	id_alloc_t           id_alloc;
	exe_resolve_t        exe_resolve;
	logic [`BP_PC_W-1:0] if_pc;
	logic                if_prediction;
	logic                flush;
	logic [`BP_PC_W-1:0] redirect_pc;

	// flat copy of the golden file, FIELDS words per cycle
	logic [15:0] golden [NUM_WORDS];

	int error_count;
	int check_count;
	int cycle_count;
	int fd;
	int vec;

	branch_predictor dut (
		.CLK           (CLK),
		.arst_n        (arst_n),
		.id_alloc      (id_alloc),
		.exe_resolve   (exe_resolve),
		.if_pc         (if_pc),
		.if_prediction (if_prediction),
		.flush         (flush),
		.redirect_pc   (redirect_pc)
	);

	// 20 ns period
	always #10 CLK = ~CLK;

	////////////////////
	// helpers
	////////////////////

	// closing count line, then the verdict
	task automatic report_and_finish();
		$display("checks run %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	// every field is at most 10 bits, leftover fill words are far above that
	function automatic bit golden_complete();
		bit ok;
		ok = 1'b1;
		for (int i = 0; i < NUM_WORDS; i++)
		begin
			if (golden[i] > 16'h03ff)
				ok = 1'b0;
		end
		return ok;
	endfunction

	// fields 0..11 are stimulus
	task automatic apply_vector(input int v);
		int b;
		b = v * FIELDS;
		id_alloc.valid        = golden[b + 0][0];
		id_alloc.is_jump      = golden[b + 1][0];
		id_alloc.is_branch    = golden[b + 2][0];
		id_alloc.pc           = golden[b + 3][`BP_PC_W-1:0];
		id_alloc.target       = golden[b + 4][`BP_PC_W-1:0];
		exe_resolve.valid     = golden[b + 5][0];
		exe_resolve.is_jump   = golden[b + 6][0];
		exe_resolve.btype     = golden[b + 7][5:0];
		exe_resolve.zero      = golden[b + 8][0];
		exe_resolve.less      = golden[b + 9][0];
		exe_resolve.pc        = golden[b + 10][`BP_PC_W-1:0];
		exe_resolve.target    = golden[b + 11][`BP_PC_W-1:0];
	endtask

	// fields 12..15 are the expected outputs
	task automatic check_vector(input int v);
		int                  b;
		logic [`BP_PC_W-1:0] exp_pc;
		logic                exp_pred;
		logic                exp_flush;
		logic [`BP_PC_W-1:0] exp_redirect;
		b            = v * FIELDS;
		exp_pc       = golden[b + 12][`BP_PC_W-1:0];
		exp_pred     = golden[b + 13][0];
		exp_flush    = golden[b + 14][0];
		exp_redirect = golden[b + 15][`BP_PC_W-1:0];
		check_count += 4;
		assert (if_pc === exp_pc)
		else
		begin
			$display("Fail at %0t ns: if_pc expected %h, got %h", $time, exp_pc, if_pc);
			error_count++;
		end
		assert (if_prediction === exp_pred)
		else
		begin
			$display("Fail at %0t ns: if_prediction expected %b, got %b",
				$time, exp_pred, if_prediction);
			error_count++;
		end
		assert (flush === exp_flush)
		else
		begin
			$display("Fail at %0t ns: flush expected %b, got %b", $time, exp_flush, flush);
			error_count++;
		end
		assert (redirect_pc === exp_redirect)
		else
		begin
			$display("Fail at %0t ns: redirect_pc expected %h, got %h",
				$time, exp_redirect, redirect_pc);
			error_count++;
		end
	endtask

	////////////////////
	// run limit
	////////////////////

	always @(posedge CLK)
	begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, stimulus did not complete", cycle_count);
			error_count++;
			report_and_finish();
		end
	end

	////////////////////
	// main sequence
	////////////////////

	initial
	begin
		CLK         = 1'b0;
		arst_n      = 1'b0;
		id_alloc    = '0;
		exe_resolve = '0;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		// fill pattern marks words the file never wrote
		for (int i = 0; i < NUM_WORDS; i++)
			golden[i] = 16'hc000 ^ 16'(i);
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0)
		begin
			$display("golden file %s is missing or cannot be read", GOLDEN_PATH);
			error_count++;
			report_and_finish();
		end
		else
		begin
			$fclose(fd);
			$readmemh(GOLDEN_PATH, golden);
			if (!golden_complete())
			begin
				$display("golden file %s is short, expected %0d vectors", GOLDEN_PATH, NUM_VEC);
				error_count++;
				report_and_finish();
			end
			else
			begin
				repeat (RESET_CYCLES) @(posedge CLK);
				#2;
				arst_n = 1'b1;
				// first vector shares the cycle in which reset drops, if_pc still 0
				for (vec = 0; vec < NUM_VEC; vec++)
				begin
					if (vec > 0)
					begin
						@(posedge CLK);
						#2;
					end
					apply_vector(vec);
					// sample 2 ns before the next edge
					#16;
					check_vector(vec);
				end
				report_and_finish();
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/branch_predictor.sv
`default_nettype none
`timescale 1ns/1ns

`include "bp_defines.svh"

module branch_predictor (
	input  wire logic                  CLK,
	input  wire logic                  arst_n,
	input  wire bp_pkg::id_alloc_t     id_alloc,
	input  wire bp_pkg::exe_resolve_t  exe_resolve,
	output logic [`BP_PC_W-1:0]        if_pc,
	output logic                       if_prediction,
	output logic                       flush,
	output logic [`BP_PC_W-1:0]        redirect_pc
);

	import bp_pkg::*;

	// set rows for each stage
	bht_entry_t [`BP_WAYS-1:0]   if_row;
	bht_entry_t [`BP_WAYS-1:0]   id_row;
	bht_entry_t [`BP_WAYS-1:0]   exe_row;

	bht_lookup_t                 if_lookup;
	bht_lookup_t                 id_lookup;
	bht_lookup_t                 exe_lookup;

	// training path from execute
	logic                        update_valid;
	logic [`BP_SET_BITS-1:0]     update_set;
	logic [$clog2(`BP_WAYS)-1:0] update_way;
	bht_entry_t                  update_entry;

	bht_store u_store (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.if_pc        (if_pc),
		.id_pc        (id_alloc.pc),
		.exe_pc       (exe_resolve.pc),
		.if_row       (if_row),
		.id_row       (id_row),
		.exe_row      (exe_row),
		.alloc        (id_alloc),
		.id_hit       (id_lookup.hit),
		.update_valid (update_valid),
		.update_set   (update_set),
		.update_way   (update_way),
		.update_entry (update_entry)
	);

	////////////////////
	// one search per stage
	////////////////////

	bht_way_match u_if_match (
		.pc      (if_pc),
		.set_row (if_row),
		.result  (if_lookup)
	);

	bht_way_match u_id_match (
		.pc      (id_alloc.pc),
		.set_row (id_row),
		.result  (id_lookup)
	);

	bht_way_match u_exe_match (
		.pc      (exe_resolve.pc),
		.set_row (exe_row),
		.result  (exe_lookup)
	);

	branch_resolve u_resolve (
		.resolve      (exe_resolve),
		.lookup       (exe_lookup),
		.update_valid (update_valid),
		.update_set   (update_set),
		.update_way   (update_way),
		.update_entry (update_entry),
		.flush        (flush),
		.redirect_pc  (redirect_pc)
	);

	// flush and redirect also leave through the top ports
	fetch_pc_unit u_fetch (
		.CLK           (CLK),
		.arst_n        (arst_n),
		.lookup        (if_lookup),
		.flush         (flush),
		.redirect_pc   (redirect_pc),
		.if_pc         (if_pc),
		.if_prediction (if_prediction)
	);

endmodule

`default_nettype wire

//--- verilog/fetch_pc_unit.sv
`default_nettype none
`timescale 1ns/1ns

`include "bp_defines.svh"

module fetch_pc_unit (
	input  wire logic                 CLK,
	input  wire logic                 arst_n,
	input  wire bp_pkg::bht_lookup_t  lookup,
	input  wire logic                 flush,
	input  wire logic [`BP_PC_W-1:0]  redirect_pc,
	output logic [`BP_PC_W-1:0]       if_pc,
	output logic                      if_prediction
);

	logic [`BP_PC_W-1:0] pc_next;

	// taken when the fetch pc hits with a strong or weak taken counter
	assign if_prediction = lookup.hit && lookup.entry.ctr[1];

	// execute correction beats the fetch guess
	always_comb
	begin
		if (flush)
		begin
			pc_next = redirect_pc;
		end
		else if (if_prediction)
		begin
			pc_next = lookup.entry.target;
		end
		else
		begin
			// sequential, addresses count instructions
			pc_next = if_pc + 1'b1;
		end
	end

	// no stalls, pc moves every cycle
	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			if_pc <= '0;
		end
		else
		begin
			if_pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/branch_resolve.sv
`default_nettype none
`timescale 1ns/1ns

`include "bp_defines.svh"

module branch_resolve (
	input  wire bp_pkg::exe_resolve_t               resolve,
	input  wire bp_pkg::bht_lookup_t                lookup,
	output logic                                    update_valid,
	output logic [`BP_SET_BITS-1:0]                 update_set,
	output logic [$clog2(`BP_WAYS)-1:0]             update_way,
	output bp_pkg::bht_entry_t                      update_entry,
	output logic                                    flush,
	output logic [`BP_PC_W-1:0]                     redirect_pc
);

	import bp_pkg::*;

	logic       active;
	logic       cond_met;
	logic       taken;
	logic       pred_taken;
	logic [1:0] ctr_next;
	bht_entry_t trained;

	// a control transfer is present in execute
	assign active = resolve.valid && (resolve.is_jump || (|resolve.btype));

	// compare outcome from the alu flags
	// signed and unsigned forms share the less flag
	assign cond_met = (resolve.btype[5] &&  resolve.zero) ||
	                  (resolve.btype[4] && !resolve.zero) ||
	                  (resolve.btype[3] &&  resolve.less) ||
	                  (resolve.btype[2] && !resolve.less) ||
	                  (resolve.btype[1] &&  resolve.less) ||
	                  (resolve.btype[0] && !resolve.less);

	assign taken = resolve.is_jump || cond_met;

	// msb of counter is the taken prediction, miss means fall through
	assign pred_taken = lookup.hit && lookup.entry.ctr[1];

	// wrong guess either way restarts fetch
	assign flush       = active && (taken != pred_taken);
	assign redirect_pc = taken ? resolve.target : resolve.pc + 1'b1;

	////////////////////
	// counter training
	////////////////////

	// saturating step toward the outcome
	always_comb
	begin
		ctr_next = lookup.entry.ctr;
		if (taken && (lookup.entry.ctr != 2'd3))
		begin
			ctr_next = lookup.entry.ctr + 2'd1;
		end
		else if (!taken && (lookup.entry.ctr != 2'd0))
		begin
			ctr_next = lookup.entry.ctr - 2'd1;
		end
	end

	// same entry back, only the counter moves
	always_comb
	begin
		trained     = lookup.entry;
		trained.ctr = ctr_next;
	end

	assign update_valid = active && lookup.hit;
	assign update_set   = resolve.pc[`BP_SET_BITS-1:0];
	assign update_way   = lookup.way;
	assign update_entry = trained;

	// decode sends at most one compare type
	always_comb
	begin
		if (resolve.valid && !$isunknown(resolve.btype))
		begin
			a_btype_onehot: assert ($onehot0(resolve.btype))
				else $error("branch resolve: btype %b is not one-hot", resolve.btype);
		end
	end

endmodule

`default_nettype wire

//--- verilog/bht_store.sv
`default_nettype none
`timescale 1ns/1ns

`include "bp_defines.svh"

module bht_store (
	input  wire logic                               CLK,
	input  wire logic                               arst_n,
	input  wire logic [`BP_PC_W-1:0]                if_pc,
	input  wire logic [`BP_PC_W-1:0]                id_pc,
	input  wire logic [`BP_PC_W-1:0]                exe_pc,
	output bp_pkg::bht_entry_t [`BP_WAYS-1:0]       if_row,
	output bp_pkg::bht_entry_t [`BP_WAYS-1:0]       id_row,
	output bp_pkg::bht_entry_t [`BP_WAYS-1:0]       exe_row,
	input  wire bp_pkg::id_alloc_t                  alloc,
	input  wire logic                               id_hit,
	input  wire logic                               update_valid,
	input  wire logic [`BP_SET_BITS-1:0]            update_set,
	input  wire logic [$clog2(`BP_WAYS)-1:0]        update_way,
	input  wire bp_pkg::bht_entry_t                 update_entry
);

	import bp_pkg::*;

	localparam int SETS = 1 << `BP_SET_BITS;

	// table, unpacked over sets, packed over ways
	bht_entry_t [`BP_WAYS-1:0]       bht_q  [SETS];
	// per set replacement pointer
	logic [$clog2(`BP_WAYS)-1:0]     fifo_q [SETS];

	logic [`BP_SET_BITS-1:0]         alloc_set;
	logic [$clog2(`BP_WAYS)-1:0]     alloc_way;
	logic                            alloc_req;
	logic                            alloc_en;
	logic                            id_tag_seen;
	bht_entry_t                      alloc_entry;

	////////////////////
	// read side
	////////////////////

	// three independent set reads
	assign if_row  = bht_q[if_pc[`BP_SET_BITS-1:0]];
	assign id_row  = bht_q[id_pc[`BP_SET_BITS-1:0]];
	assign exe_row = bht_q[exe_pc[`BP_SET_BITS-1:0]];

	////////////////////
	// allocate
	////////////////////

	assign alloc_set = alloc.pc[`BP_SET_BITS-1:0];
	// victim is the oldest way of the set
	assign alloc_way = fifo_q[alloc_set];

	// only branches and jumps that are not yet tracked
	assign alloc_req = alloc.valid && (alloc.is_jump || alloc.is_branch) && !id_hit;

	// update to the same slot wins, allocation waits for another decode
	assign alloc_en = alloc_req &&
		!(update_valid && (update_set == alloc_set) && (update_way == alloc_way));

	// new entry, counter seeded by branch kind
	always_comb
	begin
		alloc_entry.valid  = 1'b1;
		alloc_entry.tag    = alloc.pc[`BP_PC_W-1 -: `BP_TAG_W];
		alloc_entry.target = alloc.target;
		alloc_entry.ctr    = alloc.is_jump ? `BP_CTR_JUMP : `BP_CTR_BRANCH;
	end

	////////////////////
	// write side
	////////////////////

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int s = 0; s < SETS; s++)
			begin
				bht_q[s]  <= '0;
				fifo_q[s] <= '0;
			end
		end
		else
		begin
			if (alloc_en)
			begin
				bht_q[alloc_set][alloc_way] <= alloc_entry;
				// wraps modulo ways
				fifo_q[alloc_set] <= alloc_way + 2'd1;
			end
			// counter training from execute
			if (update_valid)
			begin
				bht_q[update_set][update_way] <= update_entry;
			end
		end
	end

	// own scan of the decode row, cross-checks the decode lookup
	always_comb
	begin
		id_tag_seen = 1'b0;
		for (int w = 0; w < `BP_WAYS; w++)
		begin
			if (id_row[w].valid && (id_row[w].tag == alloc.pc[`BP_PC_W-1 -: `BP_TAG_W]))
			begin
				id_tag_seen = 1'b1;
			end
		end
	end

	a_alloc_no_dup: assert property (@(posedge CLK) disable iff (!arst_n)
		alloc_en |-> !id_tag_seen)
		else $error("bht store: allocation of pc %h that already hits", alloc.pc);

endmodule

`default_nettype wire

//--- verilog/bht_way_match.sv
`default_nettype none
`timescale 1ns/1ns

`include "bp_defines.svh"

module bht_way_match (
	input  wire logic [`BP_PC_W-1:0]                pc,
	input  wire bp_pkg::bht_entry_t [`BP_WAYS-1:0]  set_row,
	output bp_pkg::bht_lookup_t                     result
);

	logic [`BP_TAG_W-1:0] pc_tag;
	logic [3:0]           match;

	// tag sits above the set index
	assign pc_tag = pc[`BP_PC_W-1 -: `BP_TAG_W];

	// per way hit, only valid ways count
	assign match[0] = set_row[0].valid && (set_row[0].tag == pc_tag);
	assign match[1] = set_row[1].valid && (set_row[1].tag == pc_tag);
	assign match[2] = set_row[2].valid && (set_row[2].tag == pc_tag);
	assign match[3] = set_row[3].valid && (set_row[3].tag == pc_tag);

	// encode the single match, miss returns all zero
	always_comb
	begin
		result = '0;
		case (match)
			4'b0001:
			begin
				result.hit   = 1'b1;
				result.way   = 2'd0;
				result.entry = set_row[0];
			end
			4'b0010:
			begin
				result.hit   = 1'b1;
				result.way   = 2'd1;
				result.entry = set_row[1];
			end
			4'b0100:
			begin
				result.hit   = 1'b1;
				result.way   = 2'd2;
				result.entry = set_row[2];
			end
			4'b1000:
			begin
				result.hit   = 1'b1;
				result.way   = 2'd3;
				result.entry = set_row[3];
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

	// the store never allocates a tag twice in one set
	always_comb
	begin
		if (!$isunknown(match))
		begin
			a_single_way: assert ($onehot0(match))
				else $error("way match: several ways hold tag %h", pc_tag);
		end
	end

endmodule

`default_nettype wire

//--- verilog/bp_pkg.sv
`default_nettype none

`include "bp_defines.svh"

package bp_pkg;

	// one table entry, 19 bits
	// valid, tag, predicted target, 2-bit saturating counter
	typedef struct packed {
		logic                 valid;
		logic [`BP_TAG_W-1:0] tag;
		logic [`BP_PC_W-1:0]  target;
		logic [1:0]           ctr;
	} bht_entry_t;

	// result of one set search
	typedef struct packed {
		logic                         hit;
		logic [$clog2(`BP_WAYS)-1:0]  way;
		bht_entry_t                   entry;
	} bht_lookup_t;

	// decode stage request to allocate a branch or jump
	typedef struct packed {
		logic                valid;
		logic                is_jump;
		logic                is_branch;
		logic [`BP_PC_W-1:0] pc;
		logic [`BP_PC_W-1:0] target;
	} id_alloc_t;

	// execute stage resolution
	// btype bit 5 beq, 4 bne, 3 blt, 2 bge, 1 bltu, 0 bgeu
	typedef struct packed {
		logic                valid;
		logic                is_jump;
		logic [5:0]          btype;
		logic                zero;
		logic                less;
		logic [`BP_PC_W-1:0] pc;
		logic [`BP_PC_W-1:0] target;
	} exe_resolve_t;

endpackage

`default_nettype wire

//--- verilog/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// instruction address width, counted in instructions
`define BP_PC_W 10

// set index taken from the low pc bits
`define BP_SET_BITS 4

// tag is whatever is left above the set index
`define BP_TAG_W 6

// associativity of the history table
`define BP_WAYS 4

// initial counter for a fresh conditional branch, weakly not taken
`define BP_CTR_BRANCH 2'd1
// jumps start strongly taken
`define BP_CTR_JUMP 2'd3

`endif
